// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_ipod_top \
  -f src.f \
  -o sim_ipod
status=$?
if [ $status -ne 0 ]; then
  echo "Build failed with status $status"
  exit $status
fi

./obj_dir/sim_ipod
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation run failed with status $status"
  exit $status
fi

exit 0

// File: source/audio_out_port.sv
`timescale 1ns/1ps

module audio_out_port (
  input  logic              CLK_50M,
  input  logic              arst_n,
  input  logic              sample_valid,
  input  ipod_pkg::sample_t sample,
  output logic              ready,
  output logic              sample_req,
  input  logic              sample_ack,
  output ipod_pkg::sample_t sample_data
);

  typedef enum logic [1:0] {
    out_idle,
    out_req,
    out_release
  } out_state_t;

  out_state_t state_q;

  assign ready      = (state_q == out_idle);
  assign sample_req = (state_q == out_req);

  // Four-phase handshake towards the codec
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      state_q <= out_idle;
    else
    begin
      case (state_q)
        out_idle:
          if (sample_valid)
            state_q <= out_req;
        out_req:
          if (sample_ack)
            state_q <= out_release;
        out_release:
          // Wait for the codec to drop its ack
          if (!sample_ack)
            state_q <= out_idle;
        default:
          state_q <= out_idle;
      endcase
    end
  end

  // Held steady for the whole handshake
  always_ff @(posedge CLK_50M)
  begin
    if (sample_valid && ready)
      sample_data <= sample;
  end

endmodule

// File: source/flash_bus_if.sv
`timescale 1ns/1ps

// Avalon-style read-only flash bus, one read outstanding
interface flash_bus_if;

  logic                  read;
  ipod_pkg::flash_addr_t address;
  logic                  waitrequest;
  ipod_pkg::flash_word_t readdata;
  logic                  readdatavalid;

  modport master (
    output read,
    output address,
    input  waitrequest,
    input  readdata,
    input  readdatavalid
  );

  modport slave (
    input  read,
    input  address,
    output waitrequest,
    output readdata,
    output readdatavalid
  );

endinterface

// File: source/flash_sample_reader.sv
`timescale 1ns/1ps

module flash_sample_reader (
  input  logic              CLK_50M,
  input  logic              arst_n,
  input  logic              tick,
  input  logic              playing,
  input  logic              forward,
  input  logic              restart_pulse,
  flash_bus_if.master       flash,
  output logic              sample_valid,
  output ipod_pkg::sample_t sample,
  input  logic              ready
);

  typedef enum logic [1:0] {
    rd_idle,
    rd_request,
    rd_wait_data,
    rd_emit
  } rd_state_t;

  rd_state_t             state_q;
  ipod_pkg::flash_addr_t addr_q;
  ipod_pkg::flash_addr_t addr_next;
  ipod_pkg::flash_word_t word_q;
  // Set once the first sample of the current word is out
  logic                  second_q;
  // Direction of the current word
  logic                  dir_q;
  logic                  restart_q;
  logic                  restart_now;
  logic                  take_tick;

  // Restart waits for the FSM to come back to idle
  assign restart_now = restart_pulse | restart_q;
  assign take_tick   = tick & playing & ready & ~restart_now & (state_q == rd_idle);

  assign sample_valid  = (state_q == rd_emit);
  // Only changes in idle, so it is stable while read is high
  assign flash.address = addr_q;

  // Next word address with wrap at both ends of the song
  always_comb
  begin
    if (dir_q)
      addr_next = (addr_q == ipod_pkg::SONG_LAST_ADDR) ? '0 : addr_q + 1'b1;
    else
      addr_next = (addr_q == '0) ? ipod_pkg::SONG_LAST_ADDR : addr_q - 1'b1;
  end

  // ==================================================
  // Control FSM
  // ==================================================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state_q    <= rd_idle;
      addr_q     <= '0;
      second_q   <= 1'b0;
      dir_q      <= 1'b1;
      restart_q  <= 1'b0;
      flash.read <= 1'b0;
    end
    else
    begin
      if (restart_pulse)
        restart_q <= 1'b1;
      case (state_q)
        rd_idle:
          if (restart_now)
          begin
            addr_q    <= '0;
            second_q  <= 1'b0;
            restart_q <= 1'b0;
          end
          else if (take_tick)
          begin
            if (second_q)
            begin
              // Word already held, finish it and move on
              second_q <= 1'b0;
              addr_q   <= addr_next;
              state_q  <= rd_emit;
            end
            else
            begin
              // Direction is taken only at a word boundary
              dir_q      <= forward;
              flash.read <= 1'b1;
              state_q    <= rd_request;
            end
          end
        rd_request:
          if (!flash.waitrequest)
          begin
            flash.read <= 1'b0;
            state_q    <= rd_wait_data;
          end
        rd_wait_data:
          if (flash.readdatavalid)
          begin
            second_q <= 1'b1;
            state_q  <= rd_emit;
          end
        rd_emit:
          state_q <= rd_idle;
        default:
          state_q <= rd_idle;
      endcase
    end
  end

  // ==================================================
  // Word and sample registers
  // ==================================================
  always_ff @(posedge CLK_50M)
  begin
    if (state_q == rd_wait_data && flash.readdatavalid)
    begin
      word_q <= flash.readdata;
      // Forward starts on the low half, backward on the high half
      if (dir_q)
        sample <= flash.readdata[ipod_pkg::LO_SAMPLE_MSB -: ipod_pkg::SAMPLE_W];
      else
        sample <= flash.readdata[ipod_pkg::HI_SAMPLE_MSB -: ipod_pkg::SAMPLE_W];
    end
    else if (take_tick && second_q)
    begin
      if (dir_q)
        sample <= word_q[ipod_pkg::HI_SAMPLE_MSB -: ipod_pkg::SAMPLE_W];
      else
        sample <= word_q[ipod_pkg::LO_SAMPLE_MSB -: ipod_pkg::SAMPLE_W];
    end
  end

endmodule

// File: source/ipod_pkg.sv
package ipod_pkg;

  // ==================================================
  // Widths
  // ==================================================
  localparam int FLASH_ADDR_W = 23;
  localparam int FLASH_DATA_W = 32;
  localparam int SAMPLE_W     = 8;
  localparam int ASCII_W      = 8;
  localparam int DIV_W        = 16;

  // MSB positions of the two samples packed in a flash word
  localparam int LO_SAMPLE_MSB = FLASH_DATA_W / 2 - 1;
  localparam int HI_SAMPLE_MSB = FLASH_DATA_W - 1;

  // ==================================================
  // Types
  // ==================================================
  typedef logic [FLASH_ADDR_W-1:0] flash_addr_t;
  typedef logic [FLASH_DATA_W-1:0] flash_word_t;
  typedef logic [SAMPLE_W-1:0]     sample_t;
  typedef logic [ASCII_W-1:0]      ascii_t;
  typedef logic [DIV_W-1:0]        div_t;

  // ==================================================
  // Sample rate divisor
  // ==================================================
  // About 22 kHz from the 50 MHz clock
  localparam div_t DIV_DEFAULT = 16'd2268;
  localparam div_t DIV_STEP    = 16'd16;
  // Clamp range, half and double the default rate
  localparam div_t DIV_MIN     = 16'd1134;
  localparam div_t DIV_MAX     = 16'd4536;

  // Last word of the song in flash
  localparam flash_addr_t SONG_LAST_ADDR = 23'h7FFFF;

  // ==================================================
  // Keyboard commands (ASCII)
  // ==================================================
  // 'E'
  localparam ascii_t KEY_START   = 8'h45;
  // 'D'
  localparam ascii_t KEY_STOP    = 8'h44;
  // 'F'
  localparam ascii_t KEY_FWD     = 8'h46;
  // 'B'
  localparam ascii_t KEY_BACK    = 8'h42;
  // 'R'
  localparam ascii_t KEY_RESTART = 8'h52;

endpackage

// File: source/ipod_top.sv
`timescale 1ns/1ps

module ipod_top (
  input  logic                  CLK_50M,
  input  logic                  arst_n,
  input  logic                  key_req,
  input  ipod_pkg::ascii_t      key_code,
  output logic                  key_ack,
  input  logic                  speed_up,
  input  logic                  speed_down,
  input  logic                  speed_reset,
  output logic                  flash_read,
  output ipod_pkg::flash_addr_t flash_address,
  input  logic                  flash_waitrequest,
  input  ipod_pkg::flash_word_t flash_readdata,
  input  logic                  flash_readdatavalid,
  output logic                  sample_req,
  output ipod_pkg::sample_t     sample_data,
  input  logic                  sample_ack
);

  logic              playing;
  logic              forward;
  logic              restart_pulse;
  logic              up_pulse;
  logic              down_pulse;
  logic              reset_pulse;
  logic              tick;
  logic              sample_valid;
  logic              ready;
  ipod_pkg::sample_t sample;

  flash_bus_if flash_bus ();

  // ==================================================
  // Flash bus to plain ports
  // ==================================================
  assign flash_read              = flash_bus.read;
  assign flash_address           = flash_bus.address;
  assign flash_bus.waitrequest   = flash_waitrequest;
  assign flash_bus.readdata      = flash_readdata;
  assign flash_bus.readdatavalid = flash_readdatavalid;

  player_cmd_decoder u_cmd_decoder (
    .CLK_50M       (CLK_50M),
    .arst_n        (arst_n),
    .key_req       (key_req),
    .key_code      (key_code),
    .key_ack       (key_ack),
    .speed_up      (speed_up),
    .speed_down    (speed_down),
    .speed_reset   (speed_reset),
    .playing       (playing),
    .forward       (forward),
    .restart_pulse (restart_pulse),
    .up_pulse      (up_pulse),
    .down_pulse    (down_pulse),
    .reset_pulse   (reset_pulse)
  );

  sample_rate_gen u_rate_gen (
    .CLK_50M     (CLK_50M),
    .arst_n      (arst_n),
    .up_pulse    (up_pulse),
    .down_pulse  (down_pulse),
    .reset_pulse (reset_pulse),
    .tick        (tick)
  );

  flash_sample_reader u_reader (
    .CLK_50M       (CLK_50M),
    .arst_n        (arst_n),
    .tick          (tick),
    .playing       (playing),
    .forward       (forward),
    .restart_pulse (restart_pulse),
    .flash         (flash_bus),
    .sample_valid  (sample_valid),
    .sample        (sample),
    .ready         (ready)
  );

  audio_out_port u_out_port (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .sample_valid (sample_valid),
    .sample       (sample),
    .ready        (ready),
    .sample_req   (sample_req),
    .sample_ack   (sample_ack),
    .sample_data  (sample_data)
  );

endmodule

// File: source/player_cmd_decoder.sv
`timescale 1ns/1ps

module player_cmd_decoder (
  input  logic             CLK_50M,
  input  logic             arst_n,
  input  logic             key_req,
  input  ipod_pkg::ascii_t key_code,
  output logic             key_ack,
  input  logic             speed_up,
  input  logic             speed_down,
  input  logic             speed_reset,
  output logic             playing,
  output logic             forward,
  output logic             restart_pulse,
  output logic             up_pulse,
  output logic             down_pulse,
  output logic             reset_pulse
);

  typedef enum logic {
    key_wait_req,
    key_wait_release
  } key_state_t;

  key_state_t key_state_q;

  // Button bits are {reset, down, up}
  logic [2:0] btn_meta_q;
  logic [2:0] btn_sync_q;
  logic [2:0] btn_prev_q;
  logic [2:0] btn_rise;

  // ==================================================
  // Key handshake and command decode
  // ==================================================
  assign key_ack = (key_state_q == key_wait_release);

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      key_state_q   <= key_wait_req;
      playing       <= 1'b0;
      forward       <= 1'b1;
      restart_pulse <= 1'b0;
    end
    else
    begin
      restart_pulse <= 1'b0;
      case (key_state_q)
        key_wait_req:
          if (key_req)
          begin
            key_state_q <= key_wait_release;
            // Unknown codes fall through and are only acknowledged
            case (key_code)
              ipod_pkg::KEY_START:   playing       <= 1'b1;
              ipod_pkg::KEY_STOP:    playing       <= 1'b0;
              ipod_pkg::KEY_FWD:     forward       <= 1'b1;
              ipod_pkg::KEY_BACK:    forward       <= 1'b0;
              ipod_pkg::KEY_RESTART: restart_pulse <= 1'b1;
              default: ;
            endcase
          end
        key_wait_release:
          if (!key_req)
            key_state_q <= key_wait_req;
        default:
          key_state_q <= key_wait_req;
      endcase
    end
  end

  // ==================================================
  // Speed buttons
  // ==================================================
  assign btn_rise = btn_sync_q & ~btn_prev_q;

  // Reset beats up, up beats down
  assign reset_pulse = btn_rise[2];
  assign up_pulse    = btn_rise[0] & ~btn_rise[2];
  assign down_pulse  = btn_rise[1] & ~btn_rise[2] & ~btn_rise[0];

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      btn_meta_q <= '0;
      btn_sync_q <= '0;
      btn_prev_q <= '0;
    end
    else
    begin
      btn_meta_q <= {speed_reset, speed_down, speed_up};
      btn_sync_q <= btn_meta_q;
      btn_prev_q <= btn_sync_q;
    end
  end

endmodule

// File: source/sample_rate_gen.sv
`timescale 1ns/1ps

module sample_rate_gen (
  input  logic CLK_50M,
  input  logic arst_n,
  input  logic up_pulse,
  input  logic down_pulse,
  input  logic reset_pulse,
  output logic tick
);

  ipod_pkg::div_t div_q;
  ipod_pkg::div_t div_next;
  ipod_pkg::div_t count_q;

  // ==================================================
  // Divisor update with clamping
  // ==================================================
  always_comb
  begin
    div_next = div_q;
    if (reset_pulse)
      div_next = ipod_pkg::DIV_DEFAULT;
    else if (up_pulse)
    begin
      // Shorter period, faster playback
      if (div_q >= ipod_pkg::DIV_MIN + ipod_pkg::DIV_STEP)
        div_next = div_q - ipod_pkg::DIV_STEP;
      else
        div_next = ipod_pkg::DIV_MIN;
    end
    else if (down_pulse)
    begin
      if (div_q <= ipod_pkg::DIV_MAX - ipod_pkg::DIV_STEP)
        div_next = div_q + ipod_pkg::DIV_STEP;
      else
        div_next = ipod_pkg::DIV_MAX;
    end
  end

  // ==================================================
  // Tick counter
  // ==================================================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      div_q   <= ipod_pkg::DIV_DEFAULT;
      count_q <= ipod_pkg::DIV_DEFAULT - 1'b1;
      tick    <= 1'b0;
    end
    else
    begin
      div_q <= div_next;
      if (div_next != div_q)
      begin
        // New rate starts a fresh period
        count_q <= div_next - 1'b1;
        tick    <= 1'b0;
      end
      else if (count_q == '0)
      begin
        count_q <= div_q - 1'b1;
        tick    <= 1'b1;
      end
      else
      begin
        count_q <= count_q - 1'b1;
        tick    <= 1'b0;
      end
    end
  end

endmodule

// File: src.f
source/ipod_pkg.sv
source/flash_bus_if.sv
source/player_cmd_decoder.sv
source/sample_rate_gen.sv
source/flash_sample_reader.sv
source/audio_out_port.sv
source/ipod_top.sv
verif/tb_flash_model.sv
verif/tb_ipod_top.sv

// File: verif/tb_flash_model.sv
`timescale 1ns/1ps

// Flash slave with random stalls and random read latency
module tb_flash_model (
  input  logic                  CLK_50M,
  input  logic                  arst_n,
  input  logic                  read,
  input  ipod_pkg::flash_addr_t address,
  output logic                  waitrequest,
  output ipod_pkg::flash_word_t readdata,
  output logic                  readdatavalid
);

  logic [31:0]           lcg_q;
  logic [1:0]            stall_q;
  logic [2:0]            lat_q;
  logic                  pending_q;
  ipod_pkg::flash_addr_t addr_q;

  function automatic logic [31:0] lcg_next(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  // Upper byte of each half holds the sample
  function automatic ipod_pkg::flash_word_t word_at(input ipod_pkg::flash_addr_t a);
    return {a[7:0] ^ 8'hA5, 8'h00, a[7:0], 8'h00};
  endfunction

  assign waitrequest = read && (stall_q != 2'd0);

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      lcg_q         <= 32'h9f24;
      stall_q       <= 2'd2;
      lat_q         <= '0;
      pending_q     <= 1'b0;
      addr_q        <= '0;
      readdata      <= '0;
      readdatavalid <= 1'b0;
    end
    else
    begin
      lcg_q         <= lcg_next(lcg_q);
      readdatavalid <= 1'b0;
      if (read && stall_q != 2'd0)
        stall_q <= stall_q - 1'b1;
      else if (read && !pending_q)
      begin
        // Accepted, pick latency now and the stall for the next read
        addr_q    <= address;
        pending_q <= 1'b1;
        lat_q     <= lcg_q[18:16];
        stall_q   <= lcg_q[25:24];
      end
      if (pending_q)
      begin
        if (lat_q == '0)
        begin
          readdatavalid <= 1'b1;
          readdata      <= word_at(addr_q);
          pending_q     <= 1'b0;
        end
        else
          lat_q <= lat_q - 1'b1;
      end
    end
  end

endmodule

// File: verif/tb_ipod_top.sv
`timescale 1ns/1ps

module tb_ipod_top;

  localparam int  PERIOD_CYC = 2268;
  localparam int  WINDOW_CYC = 20000;
  // Reset, forward, backward, five speed windows, back-pressure
  localparam int  TEST_PERIODS = 3 + 24 + 20 + 5 * 10 + 20;
  localparam real WATCHDOG_NS = 1.5 * TEST_PERIODS * PERIOD_CYC * 20.0;

  logic                  CLK_50M;
  logic                  arst_n;
  logic                  key_req;
  ipod_pkg::ascii_t      key_code;
  logic                  key_ack;
  logic                  speed_up;
  logic                  speed_down;
  logic                  speed_reset;
  logic                  flash_read;
  ipod_pkg::flash_addr_t flash_address;
  logic                  flash_waitrequest;
  ipod_pkg::flash_word_t flash_readdata;
  logic                  flash_readdatavalid;
  logic                  sample_req;
  ipod_pkg::sample_t     sample_data;
  logic                  sample_ack;

  // Reference model of the player
  string                 test_name;
  logic [31:0]           lcg_q;
  logic                  slow_ack;
  logic                  fwd_cmd;
  logic                  exp_dir;
  logic                  exp_second;
  ipod_pkg::flash_addr_t exp_addr;
  int                    exp_div;
  int                    sample_count;
  logic                  req_prev;
  logic                  outstanding;

  ipod_top dut (.*);

  tb_flash_model u_flash (
    .CLK_50M       (CLK_50M),
    .arst_n        (arst_n),
    .read          (flash_read),
    .address       (flash_address),
    .waitrequest   (flash_waitrequest),
    .readdata      (flash_readdata),
    .readdatavalid (flash_readdatavalid)
  );

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  function automatic int next_random();
    lcg_q = lcg_q * 32'd1664525 + 32'd1013904223;
    return int'(lcg_q[30:16]);
  endfunction

  // ==================================================
  // Clock, watchdog and protocol checks
  // ==================================================
  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  initial
  begin
    #(WATCHDOG_NS);
    fail_now("Watchdog expired, the test did not finish in time");
  end

  // Audio request and data held until the ack
  assert property (@(posedge CLK_50M) disable iff (!arst_n)
    (sample_req && !sample_ack) |=> (sample_req && sample_data == $past(sample_data)))
  else fail_now("sample_req or sample_data changed before sample_ack");

  // Key ack only falls once the request is gone
  assert property (@(posedge CLK_50M) disable iff (!arst_n)
    (key_ack && key_req) |=> key_ack)
  else fail_now("key_ack fell while key_req was still high");

  assert property (@(posedge CLK_50M) disable iff (!arst_n)
    (flash_read && flash_waitrequest) |=>
      (flash_read && flash_address == $past(flash_address)))
  else fail_now("flash read or address changed during waitrequest");

  assert property (@(posedge CLK_50M) disable iff (!arst_n)
    !(flash_read && outstanding))
  else fail_now("flash read issued while another read was outstanding");

  always @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      outstanding <= 1'b0;
    else if (flash_read && !flash_waitrequest)
      outstanding <= 1'b1;
    else if (flash_readdatavalid)
      outstanding <= 1'b0;
  end

  // ==================================================
  // Scoreboard
  // ==================================================
  always @(negedge CLK_50M)
  begin
    ipod_pkg::sample_t lo;
    ipod_pkg::sample_t hi;
    ipod_pkg::sample_t exp_val;
    if (sample_req && !req_prev)
    begin
      lo = exp_addr[7:0];
      hi = exp_addr[7:0] ^ 8'hA5;
      if (!exp_second)
      begin
        exp_dir    = fwd_cmd;
        exp_val    = exp_dir ? lo : hi;
        exp_second = 1'b1;
      end
      else
      begin
        exp_val    = exp_dir ? hi : lo;
        exp_second = 1'b0;
        if (exp_dir)
          exp_addr = (exp_addr == ipod_pkg::SONG_LAST_ADDR) ? '0 : exp_addr + 1'b1;
        else
          exp_addr = (exp_addr == '0) ? ipod_pkg::SONG_LAST_ADDR : exp_addr - 1'b1;
      end
      assert (sample_data == exp_val)
      else fail_now($sformatf("** Error %s: expected %h, actual %h",
                              test_name, exp_val, sample_data));
      sample_count++;
    end
    req_prev = sample_req;
  end

  // Codec side, prompt or randomly late acks
  initial
  begin
    int delay;
    sample_ack = 1'b0;
    forever
    begin
      @(negedge CLK_50M);
      if (sample_req && !sample_ack)
      begin
        delay = slow_ack ? 10 + next_random() % 50 : 1;
        repeat (delay) @(posedge CLK_50M);
        #2 sample_ack = 1'b1;
        while (sample_req) @(negedge CLK_50M);
        @(posedge CLK_50M);
        #2 sample_ack = 1'b0;
      end
    end
  end

  // ==================================================
  // Stimulus tasks
  // ==================================================
  task automatic send_key(input ipod_pkg::ascii_t code);
    while (key_ack) @(negedge CLK_50M);
    @(posedge CLK_50M);
    #2;
    key_req  = 1'b1;
    key_code = code;
    while (!key_ack) @(negedge CLK_50M);
    if (code == ipod_pkg::KEY_FWD)
      fwd_cmd = 1'b1;
    else if (code == ipod_pkg::KEY_BACK)
      fwd_cmd = 1'b0;
    else if (code == ipod_pkg::KEY_RESTART)
    begin
      exp_addr   = '0;
      exp_second = 1'b0;
    end
    @(posedge CLK_50M);
    #2 key_req = 1'b0;
    while (key_ack) @(negedge CLK_50M);
  endtask

  task automatic wait_samples(input int n);
    int target;
    target = sample_count + n;
    while (sample_count < target) @(negedge CLK_50M);
  endtask

  // Stop and let any sample in flight drain out
  task automatic stop_player();
    int at_stop;
    send_key(ipod_pkg::KEY_STOP);
    at_stop = sample_count;
    repeat (3 * PERIOD_CYC) @(negedge CLK_50M);
    assert (sample_count - at_stop <= 1)
    else fail_now($sformatf("** Error %s stop: expected <= 1, actual %0d",
                            test_name, sample_count - at_stop));
  endtask

  task automatic press_speed(input int which);
    @(posedge CLK_50M);
    #2;
    case (which)
      0: speed_up = 1'b1;
      1: speed_down = 1'b1;
      default: speed_reset = 1'b1;
    endcase
    if (which == 2)
      exp_div = ipod_pkg::DIV_DEFAULT;
    else if (which == 0)
      exp_div = (exp_div - 16 < 1134) ? 1134 : exp_div - 16;
    else
      exp_div = (exp_div + 16 > 4536) ? 4536 : exp_div + 16;
    repeat (4) @(posedge CLK_50M);
    #2;
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    repeat (4) @(posedge CLK_50M);
  endtask

  task automatic check_rate();
    int start;
    int got;
    int want;
    start = sample_count;
    repeat (WINDOW_CYC) @(negedge CLK_50M);
    got  = sample_count - start;
    want = WINDOW_CYC / exp_div;
    assert (got >= want - 1 && got <= want + 1)
    else fail_now($sformatf("** Error %s: expected %0d, actual %0d", test_name, want, got));
  endtask

  // ==================================================
  // Test sequence
  // ==================================================
  initial
  begin
    lcg_q        = 32'h9f24;
    arst_n       = 1'b0;
    key_req      = 1'b0;
    key_code     = '0;
    speed_up     = 1'b0;
    speed_down   = 1'b0;
    speed_reset  = 1'b0;
    slow_ack     = 1'b0;
    fwd_cmd      = 1'b1;
    exp_dir      = 1'b1;
    exp_second   = 1'b0;
    exp_addr     = '0;
    exp_div      = ipod_pkg::DIV_DEFAULT;
    sample_count = 0;
    req_prev     = 1'b0;
    test_name    = "reset";
    repeat (16) @(posedge CLK_50M);
    #2 arst_n = 1'b1;

    @(negedge CLK_50M);
    assert (!key_ack && !sample_req && !flash_read)
    else fail_now("Outputs not idle after reset");
    repeat (3 * PERIOD_CYC) @(negedge CLK_50M);
    assert (sample_count == 0)
    else fail_now($sformatf("** Error %s: expected 0, actual %0d", test_name, sample_count));

    test_name = "forward";
    send_key(ipod_pkg::KEY_RESTART);
    send_key(ipod_pkg::KEY_START);
    wait_samples(16);
    stop_player();

    test_name = "backward";
    send_key(ipod_pkg::KEY_BACK);
    send_key(ipod_pkg::KEY_RESTART);
    send_key(ipod_pkg::KEY_START);
    wait_samples(4);
    send_key(8'h5A);
    send_key(8'h00);
    wait_samples(8);
    stop_player();

    test_name = "speed";
    send_key(ipod_pkg::KEY_FWD);
    send_key(ipod_pkg::KEY_START);
    check_rate();
    // Enough presses to reach the lower clamp
    repeat (80) press_speed(0);
    check_rate();
    repeat (40) press_speed(1);
    check_rate();
    // Runs past the upper clamp
    repeat (200) press_speed(1);
    check_rate();
    press_speed(2);
    check_rate();

    test_name = "backpressure";
    slow_ack = 1'b1;
    wait_samples(12);
    stop_player();

    $display("Simulation PASSED");
    $finish;
  end

endmodule
